/* list.f */
design/bp_pkg.sv
design/index_hash.sv
design/pred_table.sv
design/global_history.sv
design/direction_predictor.sv
design/target_predictor.sv
design/branch_predictor.sv
dv/clk_gen.sv
dv/branch_predictor_properties.sv
dv/branch_predictor_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= branch_predictor_tb
FLIST     ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= All tests passed
VFLAGS    ?= --timing --assert
SIM_ARGS  ?= +verilator+error+limit+1000

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

sim: build
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* dv/branch_predictor_tb.sv */
`default_nettype none

module branch_predictor_tb import bp_pkg::*; ();

    localparam int num_cycles = 600;
    localparam int pool_size = 16;
    localparam int timeout = (num_cycles + 16 + 50) * 10;
    localparam int unsigned seed = 32'h6d04_d3aa;
    // one bit in each of two slices, cancels in the fold
    localparam logic [addr_width-1:0] alias_xor = (addr_width'(1) << idx_width) | addr_width'(1);

    logic                  clk;
    logic                  rstn;
    logic                  stall;
    logic                  update_en;
    logic [addr_width-1:0] pc;
    resolve_t              ex;
    pred_t                 pred;

    int errors = 0;
    int checks = 0;

    // reference state
    kind_t                 m_kind [table_depth];
    hist_t                 m_lh [table_depth];
    logic [1:0]            m_lcnt [table_depth];
    logic [1:0]            m_gcnt [table_depth];
    logic [1:0]            m_ch [table_depth];
    logic [addr_width-1:0] m_btb [table_depth];
    logic [addr_width-1:0] m_stack [stack_len];
    ras_ptr_t              m_sp;
    hist_t                 m_gh;
    logic [addr_width-1:0] m_pc;
    kind_t                 q_kind;
    hist_t                 q_lh;
    logic                  q_dir;
    logic [addr_width-1:0] q_btb;
    hist_t                 used_lh;
    hist_t                 used_gh;

    logic [addr_width-1:0] pool [pool_size];
    kind_t                 pool_kind [pool_size];
    logic [addr_width-1:0] pool_tgt [pool_size];
    pred_t                 seen [pool_size];
    bit                    seen_ok [pool_size];
    int                    cur_slot; // pool slot held in pc_reg, -1 for none
    int                    pc_slot;

    clk_gen clk_gen0 (.clk(clk), .rstn(rstn));

    branch_predictor dut0 (
        .clk(clk),
        .rstn(rstn),
        .stall(stall),
        .update_en(update_en),
        .pc(pc),
        .ex(ex),
        .pred(pred)
    );

    bind branch_predictor branch_predictor_properties props0 (
        .clk(clk), .rstn(rstn), .stall(stall), .pred(pred)
    );

    function automatic idx_t fold(input logic [addr_width-1:0] a, input hist_t h);
        idx_t r;
        r = idx_t'(h);
        for (int s = 0; s < addr_width; s += idx_width) begin
            r = r ^ a[s +: idx_width];
        end
        return r;
    endfunction

    function automatic logic [1:0] saturate(input logic [1:0] c, input logic up);
        if (up) begin
            return (c == 2'd3) ? c : c + 2'd1;
        end
        return (c == 2'd0) ? c : c - 2'd1;
    endfunction

    function automatic kind_t pick_kind(input int unsigned r);
        case (r % 8)
            0, 1:    return not_jump;
            2, 3:    return direct_jump;
            4:       return call;
            5:       return ret;
            6:       return jump;
            default: return indirect_jump;
        endcase
    endfunction

    function automatic pred_t expect_pred();
        pred_t p;
        p.kind = q_kind;
        case (q_kind)
            not_jump:    p.taken = 1'b0;
            direct_jump: p.taken = q_dir;
            default:     p.taken = 1'b1;
        endcase
        if (!p.taken) begin
            p.npc = m_pc + 1'b1;
        end else if (q_kind == ret) begin
            p.npc = m_stack[m_sp - 1'b1];
        end else begin
            p.npc = q_btb;
        end
        p.lh = used_lh;
        p.gh = used_gh;
        return p;
    endfunction

    task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch %s: got %0h, expected %0h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_pred();
        pred_t e;
        e = expect_pred();
        compare("pred.kind", 64'(pred.kind), 64'(e.kind));
        compare("pred.taken", 64'(pred.taken), 64'(e.taken));
        compare("pred.npc", 64'(pred.npc), 64'(e.npc));
        compare("pred.lh", 64'(pred.lh), 64'(e.lh));
        compare("pred.gh", 64'(pred.gh), 64'(e.gh));
    endtask

    task automatic reset_tables();
        for (int i = 0; i < table_depth; i++) begin
            m_kind[i] = not_jump;
            m_lh[i] = '0;
            m_lcnt[i] = 2'd1; // weakly not taken
            m_gcnt[i] = 2'd1;
            m_ch[i] = 2'd1;
            m_btb[i] = '0;
        end
        for (int i = 0; i < stack_len; i++) begin
            m_stack[i] = '0;
        end
        m_sp = '0;
        m_gh = '0;
        m_pc = reset_pc;
        q_kind = not_jump;
        q_lh = '0;
        q_dir = 1'b0;
        q_btb = '0;
        used_lh = '0;
        used_gh = '0;
    endtask

    // one rising edge of the reference, from the inputs held across it
    task automatic advance_model();
        pred_t cur;
        idx_t  fi, ei, li, gi, eli, egi;
        logic  l_ok, g_ok;
        cur = expect_pred();
        fi = fold(pc, '0);
        ei = fold(ex.addr, '0);
        li = fold(pc, q_lh);
        gi = fold(pc, m_gh);
        eli = fold(ex.addr, ex.lh);
        egi = fold(ex.addr, ex.gh);
        if (update_en) begin // writes land before the reads below
            m_kind[ei] = ex.kind;
            if (ex.kind != not_jump) begin
                m_lh[ei] = {ex.lh[hist_width-2:0], ex.taken};
            end
            if (ex.kind == direct_jump) begin
                l_ok = m_lcnt[eli][1] == ex.taken;
                g_ok = m_gcnt[egi][1] == ex.taken;
                m_lcnt[eli] = saturate(m_lcnt[eli], ex.taken);
                m_gcnt[egi] = saturate(m_gcnt[egi], ex.taken);
                if (g_ok != l_ok) begin
                    m_ch[egi] = saturate(m_ch[egi], g_ok);
                end
            end
            if (ex.taken && ex.kind != not_jump && ex.kind != ret) begin
                m_btb[ei] = ex.npc;
            end
        end
        if (!stall) begin
            if (cur.taken && cur.kind == call) begin
                m_stack[m_sp] = m_pc + 1'b1;
                m_sp = m_sp + 1'b1;
            end else if (cur.taken && cur.kind == ret) begin
                m_sp = m_sp - 1'b1;
            end
            used_lh = q_lh;
            used_gh = m_gh;
            q_dir = m_ch[gi][1] ? m_gcnt[gi][1] : m_lcnt[li][1];
            q_kind = m_kind[fi];
            q_lh = m_lh[fi];
            q_btb = m_btb[fi];
            m_pc = pc;
            cur_slot = pc_slot;
        end
        if (update_en && ex.mis_taken) begin
            m_gh = {ex.gh[hist_width-2:0], ex.taken};
        end else if (!stall && cur.kind != not_jump) begin
            m_gh = {m_gh[hist_width-2:0], cur.taken};
        end
    endtask

    // execute packet for slot s, built on the last prediction seen there
    task automatic make_resolve(input int s);
        pred_t p;
        p = seen[s];
        ex.addr = pool[s];
        ex.kind = pool_kind[s];
        case (pool_kind[s])
            not_jump:    ex.taken = 1'b0;
            direct_jump: ex.taken = 1'($urandom);
            default:     ex.taken = 1'b1;
        endcase
        if (!ex.taken) begin
            ex.npc = pool[s] + 1'b1;
        end else if (pool_kind[s] == ret || pool_kind[s] == indirect_jump) begin
            ex.npc = pool[int'($urandom % pool_size)];
        end else begin
            ex.npc = pool_tgt[s];
        end
        ex.lh = p.lh;
        ex.gh = p.gh;
        ex.mis_taken = ex.taken != p.taken;
        ex.mis_npc = ex.npc != p.npc;
    endtask

    task automatic drive_inputs();
        int s;
        pc_slot = int'($urandom % pool_size);
        pc = pool[pc_slot];
        stall = ($urandom % 100) < 15;
        s = int'($urandom % pool_size);
        if (($urandom % 100) < 40 && seen_ok[s]) begin
            make_resolve(s);
            update_en = 1'b1;
        end else begin
            update_en = 1'b0;
            ex = '0;
        end
    endtask

    initial begin
        void'($urandom(seed));
        stall = 1'b0;
        update_en = 1'b0;
        pc = '0;
        ex = '0;
        for (int i = 0; i < pool_size / 2; i++) begin
            pool[i] = addr_width'($urandom);
            pool[i + pool_size / 2] = pool[i] ^ alias_xor; // same table index
        end
        for (int i = 0; i < pool_size; i++) begin
            pool_kind[i] = pick_kind($urandom);
            pool_tgt[i] = addr_width'($urandom);
            seen_ok[i] = 1'b0;
        end
        reset_tables();
        cur_slot = -1;
        pc_slot = -1;
        @(posedge rstn);
        check_pred();
        for (int n = 0; n < num_cycles; n++) begin
            drive_inputs();
            @(posedge clk);
            advance_model();
            #1;
            check_pred();
            if (cur_slot >= 0) begin
                seen[cur_slot] = expect_pred();
                seen_ok[cur_slot] = 1'b1;
            end
        end
        $display("checks %0d, errors %0d, assertion failures %0d",
                 checks, errors, dut0.props0.fail_count);
        if (errors == 0 && dut0.props0.fail_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    initial begin
        #(timeout);
        $display("Timeout: the run did not reach its end within %0d time units", timeout);
        $display("Some tests failed");
        $finish;
    end

endmodule

`default_nettype wire

/* dv/branch_predictor_properties.sv */
`default_nettype none

module branch_predictor_properties import bp_pkg::*; (
    input logic  clk,
    input logic  rstn,
    input logic  stall,
    input pred_t pred
);

    int unsigned fail_count = 0; // read by the testbench at the end

    hold_on_stall: assert property (@(posedge clk) disable iff (!rstn)
        stall |=> $stable(pred))
    else begin
        $error("pred changed while stall was high");
        fail_count++;
    end

    kind_defined: assert property (@(posedge clk) disable iff (!rstn)
        pred.kind inside {not_jump, direct_jump, ret, indirect_jump, call, jump})
    else begin
        $error("pred.kind holds an undefined code");
        fail_count++;
    end

    not_jump_not_taken: assert property (@(posedge clk) disable iff (!rstn)
        pred.kind == not_jump |-> !pred.taken)
    else begin
        $error("pred.taken set for a not_jump");
        fail_count++;
    end

endmodule

`default_nettype wire

/* dv/clk_gen.sv */
`default_nettype none

module clk_gen (
    output logic clk,
    output logic rstn
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        rstn = 1'b0;
        repeat (16) @(posedge clk);
        #1 rstn = 1'b1; // released just after the edge
    end

endmodule

`default_nettype wire

/* design/branch_predictor.sv */
`default_nettype none

module branch_predictor import bp_pkg::*; (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  stall,
    input  logic                  update_en,
    input  logic [addr_width-1:0] pc,
    input  resolve_t              ex,
    output pred_t                 pred
);

    logic [addr_width-1:0] pc_reg;
    logic [addr_width-1:0] npc;
    idx_t                  fetch_idx;
    idx_t                  ex_idx;
    idx_t                  l_idx;
    idx_t                  g_idx;
    idx_t                  ex_l_idx;
    idx_t                  ex_g_idx;
    hist_t                 gh;
    hist_t                 lh_rd;
    hist_t                 lh_used;
    hist_t                 gh_used;
    hist_t                 lh_new;
    kind_t                 kind_rd;
    logic                  taken_pdc;
    logic                  lh_wr;

    // histories that built this lookup's indices travel with the prediction
    always_ff @(posedge clk) begin
        if (!rstn) begin
            pc_reg <= reset_pc;
            lh_used <= '0;
            gh_used <= '0;
        end else if (!stall) begin
            pc_reg <= pc;
            lh_used <= lh_rd;
            gh_used <= gh;
        end
    end

    index_hash #(.in_width(addr_width), .h_width(1)) hash_fetch (
        .data(pc), .hist(1'b0), .index(fetch_idx)
    );
    index_hash #(.in_width(addr_width), .h_width(1)) hash_ex (
        .data(ex.addr), .hist(1'b0), .index(ex_idx)
    );
    index_hash #(.in_width(addr_width), .h_width(hist_width)) hash_l (
        .data(pc), .hist(lh_rd), .index(l_idx)
    );
    index_hash #(.in_width(addr_width), .h_width(hist_width)) hash_g (
        .data(pc), .hist(gh), .index(g_idx)
    );
    index_hash #(.in_width(addr_width), .h_width(hist_width)) hash_ex_l (
        .data(ex.addr), .hist(ex.lh), .index(ex_l_idx)
    );
    index_hash #(.in_width(addr_width), .h_width(hist_width)) hash_ex_g (
        .data(ex.addr), .hist(ex.gh), .index(ex_g_idx)
    );

    pred_table #(.entry_t(kind_t)) kind_table (
        .clk(clk),
        .rstn(rstn),
        .rd_en(!stall),
        .rd_idx(fetch_idx),
        .rd_data(kind_rd),
        .wr_en(update_en),
        .wr_idx(ex_idx),
        .wr_data(ex.kind)
    );

    assign lh_wr = update_en && ex.kind != not_jump;
    assign lh_new = {ex.lh[hist_width-2:0], ex.taken}; // real outcome in at bit 0

    pred_table #(.entry_t(hist_t)) lh_table (
        .clk(clk),
        .rstn(rstn),
        .rd_en(!stall),
        .rd_idx(fetch_idx),
        .rd_data(lh_rd),
        .wr_en(lh_wr),
        .wr_idx(ex_idx),
        .wr_data(lh_new)
    );

    global_history ghr (
        .clk(clk),
        .rstn(rstn),
        .stall(stall),
        .shift_en(kind_rd != not_jump),
        .taken(taken_pdc),
        .recover(update_en && ex.mis_taken),
        .snapshot(ex.gh),
        .taken_real(ex.taken),
        .gh(gh)
    );

    direction_predictor dir_pred (
        .clk(clk),
        .rstn(rstn),
        .stall(stall),
        .l_idx(l_idx),
        .g_idx(g_idx),
        .kind(kind_rd),
        .update_en(update_en),
        .ex(ex),
        .ex_l_idx(ex_l_idx),
        .ex_g_idx(ex_g_idx),
        .taken_pdc(taken_pdc)
    );

    target_predictor tgt_pred (
        .clk(clk),
        .rstn(rstn),
        .stall(stall),
        .idx(fetch_idx),
        .pc_reg(pc_reg),
        .kind(kind_rd),
        .taken(taken_pdc),
        .update_en(update_en),
        .ex(ex),
        .ex_idx(ex_idx),
        .npc(npc)
    );

    assign pred = '{kind: kind_rd, taken: taken_pdc, npc: npc, lh: lh_used, gh: gh_used};

endmodule

`default_nettype wire

/* design/target_predictor.sv */
`default_nettype none

module target_predictor import bp_pkg::*; (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  stall,
    input  idx_t                  idx,
    input  logic [addr_width-1:0] pc_reg,
    input  kind_t                 kind,
    input  logic                  taken,
    input  logic                  update_en,
    input  resolve_t              ex,
    input  idx_t                  ex_idx,
    output logic [addr_width-1:0] npc
);

    logic [addr_width-1:0] btb [table_depth];
    logic [addr_width-1:0] stack [stack_len];
    logic [addr_width-1:0] btb_q;
    logic [addr_width-1:0] fall_pc;
    ras_ptr_t              ptr;     // next free slot
    ras_ptr_t              top_ptr;
    logic                  btb_wr;
    logic                  push;
    logic                  pop;

    assign btb_wr = update_en && ex.taken && ex.kind != not_jump && ex.kind != ret;
    assign fall_pc = pc_reg + addr_width'(1);
    assign top_ptr = ptr - ras_ptr_t'(1);
    assign push = !stall && taken && kind == call;
    assign pop = !stall && taken && kind == ret;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < table_depth; i++) begin
                btb[i] <= '0;
            end
            btb_q <= '0;
        end else begin
            if (btb_wr) begin
                btb[ex_idx] <= ex.npc;
            end
            if (!stall) begin
                btb_q <= (btb_wr && ex_idx == idx) ? ex.npc : btb[idx];
            end
        end
    end

    // return stack, pointer wraps on overflow
    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < stack_len; i++) begin
                stack[i] <= '0;
            end
            ptr <= '0;
        end else if (push) begin
            stack[ptr] <= fall_pc;
            ptr <= ptr + ras_ptr_t'(1);
        end else if (pop) begin
            ptr <= top_ptr;
        end
    end

    always_comb begin
        if (!taken) begin
            npc = fall_pc;
        end else if (kind == ret) begin
            npc = stack[top_ptr];
        end else begin
            npc = btb_q;
        end
    end

endmodule

`default_nettype wire

/* design/direction_predictor.sv */
`default_nettype none

module direction_predictor import bp_pkg::*; (
    input  logic     clk,
    input  logic     rstn,
    input  logic     stall,
    input  idx_t     l_idx,
    input  idx_t     g_idx,
    input  kind_t    kind,
    input  logic     update_en,
    input  resolve_t ex,
    input  idx_t     ex_l_idx,
    input  idx_t     ex_g_idx,
    output logic     taken_pdc
);

    logic [1:0] l_cnt [table_depth];
    logic [1:0] g_cnt [table_depth];
    logic [1:0] chooser [table_depth]; // upper bit high selects global

    logic       train;
    logic       l_right;
    logic       g_right;
    logic [1:0] l_new;
    logic [1:0] g_new;
    logic [1:0] ch_new;
    logic [1:0] l_rd;
    logic [1:0] g_rd;
    logic [1:0] ch_rd;
    logic       taken_q;

    function automatic logic [1:0] step(input logic [1:0] c, input logic up);
        if (up) begin
            return (c == 2'd3) ? c : c + 2'd1;
        end
        return (c == 2'd0) ? c : c - 2'd1;
    endfunction

    assign train = update_en && ex.kind == direct_jump;
    assign l_right = l_cnt[ex_l_idx][1] == ex.taken;
    assign g_right = g_cnt[ex_g_idx][1] == ex.taken;

    always_comb begin
        l_new = step(l_cnt[ex_l_idx], ex.taken);
        g_new = step(g_cnt[ex_g_idx], ex.taken);
        ch_new = chooser[ex_g_idx];
        if (g_right && !l_right) begin
            ch_new = step(ch_new, 1'b1);
        end else if (l_right && !g_right) begin
            ch_new = step(ch_new, 1'b0);
        end
    end

    // forward a training write to the same index
    assign l_rd = (train && ex_l_idx == l_idx) ? l_new : l_cnt[l_idx];
    assign g_rd = (train && ex_g_idx == g_idx) ? g_new : g_cnt[g_idx];
    assign ch_rd = (train && ex_g_idx == g_idx) ? ch_new : chooser[g_idx];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < table_depth; i++) begin
                l_cnt[i] <= 2'd1;   // weakly not taken
                g_cnt[i] <= 2'd1;
                chooser[i] <= 2'd1;
            end
            taken_q <= 1'b0;
        end else begin
            if (train) begin
                l_cnt[ex_l_idx] <= l_new;
                g_cnt[ex_g_idx] <= g_new;
                chooser[ex_g_idx] <= ch_new;
            end
            if (!stall) begin
                taken_q <= ch_rd[1] ? g_rd[1] : l_rd[1];
            end
        end
    end

    always_comb begin
        case (kind)
            direct_jump:                     taken_pdc = taken_q;
            jump, call, indirect_jump, ret:  taken_pdc = 1'b1;
            default:                         taken_pdc = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

/* design/global_history.sv */
`default_nettype none

module global_history import bp_pkg::*; (
    input  logic  clk,
    input  logic  rstn,
    input  logic  stall,
    input  logic  shift_en,
    input  logic  taken,
    input  logic  recover,
    input  hist_t snapshot,
    input  logic  taken_real,
    output hist_t gh
);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            gh <= '0;
        end else if (recover) begin
            // history as it stood after the resolved branch
            gh <= {snapshot[hist_width-2:0], taken_real};
        end else if (!stall && shift_en) begin
            gh <= {gh[hist_width-2:0], taken}; // speculative
        end
    end

endmodule

`default_nettype wire

/* design/pred_table.sv */
`default_nettype none

module pred_table import bp_pkg::*; #(
    parameter type entry_t = logic
) (
    input  logic   clk,
    input  logic   rstn,
    input  logic   rd_en,
    input  idx_t   rd_idx,
    output entry_t rd_data,
    input  logic   wr_en,
    input  idx_t   wr_idx,
    input  entry_t wr_data
);

    entry_t mem [table_depth];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < table_depth; i++) begin
                mem[i] <= entry_t'(0);
            end
            rd_data <= entry_t'(0);
        end else begin
            if (wr_en) begin
                mem[wr_idx] <= wr_data;
            end
            if (rd_en) begin
                // same index write wins
                rd_data <= (wr_en && wr_idx == rd_idx) ? wr_data : mem[rd_idx];
            end
        end
    end

endmodule

`default_nettype wire

/* design/index_hash.sv */
`default_nettype none

module index_hash import bp_pkg::*; #(
    parameter int in_width = addr_width,
    parameter int h_width = hist_width
) (
    input  logic [in_width-1:0] data,
    input  logic [h_width-1:0]  hist,
    output idx_t                index
);

    // xor of idx_width slices, lowest slice first
    always_comb begin
        index = '0;
        for (int i = 0; i < in_width; i++) begin
            index[i % idx_width] ^= data[i];
        end
        for (int j = 0; j < h_width; j++) begin
            index[j % idx_width] ^= hist[j];
        end
    end

endmodule

`default_nettype wire

/* design/bp_pkg.sv */
`default_nettype none

package bp_pkg;

    localparam int addr_width = 30;
    localparam int idx_width = 6;
    localparam int table_depth = 1 << idx_width;
    localparam int hist_width = 6;
    localparam int stack_len = 8;
    localparam int ras_ptr_width = $clog2(stack_len);

    localparam logic [addr_width-1:0] reset_pc = 30'h0700_0000;

    typedef logic [idx_width-1:0] idx_t;
    typedef logic [hist_width-1:0] hist_t;
    typedef logic [ras_ptr_width-1:0] ras_ptr_t;

    typedef enum logic [2:0] {
        not_jump      = 3'd0,
        direct_jump   = 3'd1,
        ret           = 3'd4,
        indirect_jump = 3'd5,
        call          = 3'd6,
        jump          = 3'd7
    } kind_t;

    typedef struct packed {
        kind_t                 kind;
        logic                  taken;
        logic [addr_width-1:0] npc;
        hist_t                 lh;   // local history used for the lookup
        hist_t                 gh;   // global history used for the lookup
    } pred_t;

    // built by execute from a returned pred_t and the real outcome
    typedef struct packed {
        logic [addr_width-1:0] addr;
        kind_t                 kind;
        logic                  taken;
        logic [addr_width-1:0] npc;
        hist_t                 lh;
        hist_t                 gh;
        logic                  mis_taken;
        logic                  mis_npc;
    } resolve_t;

endpackage

`default_nettype wire
